// File: divider_consts.svh
`ifndef DIVIDER_CONSTS_SVH
`define DIVIDER_CONSTS_SVH

// operand, quotient and remainder word
`define DIV_WIDTH 32

// carry-save remainder with three guard bits and one alignment bit
`define REM_WIDTH 36

// truncated remainder estimate seen by the digit table
`define QST_SUM_BITS 7

// divisor bits below the leading one
`define QST_DIV_BITS 3

// longest iterate phase (divisor of one)
`define MAX_ITER 18

`endif

// File: divPkg.sv
`include "divider_consts.svh"

package divPkg;

   typedef logic [`DIV_WIDTH-1:0] word_t;
   typedef logic [$clog2(`DIV_WIDTH)-1:0] shiftAmt_t;     // leading zeros of the divisor
   typedef logic [$clog2(`MAX_ITER+1)-1:0] iterCount_t;
   typedef logic [`REM_WIDTH-1:0] partialRem_t;
   typedef logic [`DIV_WIDTH:0] quotAcc_t;                // one spare bit over the quotient

   // one-hot digit ordered +2 +1 -1 -2 from the msb
   typedef logic [3:0] digit_t;

   typedef struct packed {
      word_t dividend;
      word_t divisor;
   } divRequest_t;

   typedef struct packed {
      word_t quotient;
      word_t remainder;
      logic  divZero;
   } divResult_t;

   typedef enum logic [1:0] {
      stIdle,
      stLoad,
      stIterate,
      stAck
   } divState_t;

endpackage

// File: quotientSelect.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module quotientSelect import divPkg::*;
(
   input  logic [`QST_SUM_BITS-1:0] remEstimate,
   input  logic [`QST_DIV_BITS-1:0] divisorTop,
   output digit_t                   digit
);

   logic [`QST_SUM_BITS-1:0] s;
   logic [`QST_DIV_BITS-1:0] d;

   // s is the two's complement estimate and d the divisor fraction after its leading one
   assign s = remEstimate;
   assign d = divisorTop;

   // +2 when the estimate is well above 4/3 d
   assign digit[3] = ~s[6] & (s[5]
                     | (~d[2] & s[4])
                     | (s[4] & s[3])
                     | (~d[1] & s[4] & s[2])
                     | (~d[0] & s[4] & s[2])
                     | (~d[1] & ~d[0] & s[4] & s[1])
                     | (~d[2] & ~d[1] & ~d[0] & s[3] & s[2])
                     | (~d[2] & ~d[1] & s[3] & s[2] & s[1])
                     | (~d[2] & ~d[0] & s[3] & s[2] & s[1] & s[0]));

   // +1
   assign digit[2] = ~s[6] & ~s[5] & (
                       (~s[4] & ((d[2] & s[3])
                                 | (s[3] & ~s[2])
                                 | (~d[2] & ~s[3] & s[2])
                                 | (~d[2] & d[1] & d[0] & s[2])
                                 | (~d[1] & ~s[3] & s[2] & s[1])
                                 | (~d[2] & d[1] & s[2] & ~s[1])
                                 | (~d[2] & d[0] & s[2] & ~s[1])
                                 | (~d[2] & d[1] & s[2] & ~s[0])))
                     | (s[4] & ~s[3] & ((d[2] & d[1] & d[0])
                                        | (d[2] & d[1] & ~s[2])
                                        | (d[2] & d[0] & ~s[2])
                                        | (d[2] & ~s[2] & ~s[1]))));

   // -1 for small negative estimates
   assign digit[1] = s[6] & s[5] & (
                       (s[4] & ~s[3] & (d[2] | d[1] | s[2] | (d[0] & s[1])))
                     | (~s[4] & s[3] & ((d[2] & s[2])
                                        | (d[2] & d[1] & d[0])
                                        | (d[2] & d[1] & s[1])
                                        | (d[1] & d[0] & s[2] & s[1])))
                     | (s[4] & s[3] & ((~d[2] & ~s[2] & ~s[1])
                                       | (~d[2] & ~d[1] & ~d[0] & ~s[2])))
                     | (s[4] & ~s[2] & s[0] & ((~d[2] & d[0] & ~s[1])
                                               | (~d[2] & ~d[1] & ~d[0] & s[1]))));

   // -2
   assign digit[0] = s[6] & (~s[5]
                     | (~s[4] & (~s[3]
                                 | (~d[2] & ~d[1])
                                 | (~d[2] & ~d[0])
                                 | (~d[2] & ~s[2])
                                 | (~d[1] & ~s[2])
                                 | (~d[2] & ~s[1])
                                 | (~d[0] & ~s[2] & ~s[1])))
                     | (~s[3] & ~s[2] & ((~d[2] & ~d[1] & ~d[0] & ~s[1])
                                         | (~d[2] & ~d[1] & ~d[0] & ~s[0])
                                         | (~d[2] & ~d[1] & ~s[1] & ~s[0]))));

endmodule

// File: divNormalize.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module divNormalize import divPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        capture,
   input  divRequest_t request,
   output word_t       dividend,
   output word_t       divisorNorm,
   output shiftAmt_t   shiftAmt,
   output logic        oddShift,
   output iterCount_t  numIter,
   output logic        divZero
);

   localparam int levels = $bits(shiftAmt_t);

   word_t stage [levels+1];
   shiftAmt_t zeroCount;
   logic [levels:0] iterSum;

   assign stage[0] = request.divisor;

   // halving windows of 16 8 4 2 1 bits give one count bit each
   for (genvar i = 0; i < levels; i++)
   begin : gLzLevel
      localparam int span = (`DIV_WIDTH / 2) >> i;

      assign zeroCount[levels-1-i] = (stage[i][`DIV_WIDTH-1 -: span] == '0);
      assign stage[i+1] = zeroCount[levels-1-i] ? (stage[i] << span) : stage[i];
   end

   // ceil((shift + 4) / 2) covers the radix-4 digits plus the finish cycle
   assign iterSum = {1'b0, zeroCount} + 6'd5;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         shiftAmt <= '0;
         oddShift <= 1'b0;
         numIter <= '0;
         divZero <= 1'b0;
      end
      else if (capture)
      begin
         shiftAmt <= zeroCount;
         oddShift <= zeroCount[0];   // odd shift keeps the dividend unscaled
         numIter <= iterSum[levels:1];
         divZero <= (request.divisor == '0);
      end
   end

   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         dividend <= request.dividend;
         divisorNorm <= stage[levels];   // leading one now at the msb
      end
   end

endmodule

// File: divControl.sv
`timescale 1ns/1ps

module divControl import divPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       req,
   input  iterCount_t numIter,
   input  logic       divZero,
   output logic       capture,
   output logic       load,
   output logic       iterate,
   output logic       finish,
   output logic       ack
);

   divState_t state;
   divState_t nextState;
   iterCount_t stepsLeft;     // cycles still to spend in stIterate

   assign capture = (state == stIdle) && req && !ack;
   assign load = (state == stLoad);

   // last cycle of stIterate only latches the corrected result
   assign iterate = (state == stIterate) && (stepsLeft > iterCount_t'(1));
   assign finish = (state == stIterate) && (stepsLeft <= iterCount_t'(1));

   always_comb
   begin
      nextState = state;
      case (state)
         stIdle:
            if (capture)
               nextState = stLoad;
         stLoad:
            nextState = divZero ? stAck : stIterate;   // nothing to compute for zero
         stIterate:
            if (finish)
               nextState = stAck;
         stAck:
            if (!req)
               nextState = stIdle;
         default:
            nextState = stIdle;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= stIdle;
         stepsLeft <= '0;
         ack <= 1'b0;
      end
      else
      begin
         state <= nextState;
         if (load)
            stepsLeft <= numIter;
         else if (iterate)
            stepsLeft <= stepsLeft - iterCount_t'(1);

         // rises a cycle into stAck and drops on the first edge that sees req low
         ack <= (state == stAck) && req;
      end
   end

endmodule

// File: srtIteration.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module srtIteration import divPkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     load,
   input  logic                     iterate,
   input  logic                     finish,
   input  word_t                    dividend,
   input  word_t                    divisorNorm,
   input  shiftAmt_t                shiftAmt,
   input  logic                     oddShift,
   input  digit_t                   digit,
   output logic [`QST_SUM_BITS-1:0] remEstimate,
   output logic [`QST_DIV_BITS-1:0] divisorTop,
   output word_t                    quotient,
   output word_t                    remainder
);

   partialRem_t sumReg;       // residual before the x4 shift
   partialRem_t carryReg;
   partialRem_t sumIn;
   partialRem_t carryIn;
   partialRem_t carryUlp;
   partialRem_t divOne;
   partialRem_t divTwo;
   partialRem_t divMultiple;
   partialRem_t csaSum;
   partialRem_t csaCarry;
   partialRem_t remRaw;
   partialRem_t remFixed;
   logic [`QST_SUM_BITS:0] estimate;
   logic firstStep;
   logic posDigit;
   logic negDigit;
   logic [1:0] qIn;
   logic [1:0] qmIn;
   quotAcc_t quotQ;           // on-the-fly Q
   quotAcc_t quotQm;          // and Q-1
   quotAcc_t quotQBase;
   quotAcc_t quotQmBase;
   quotAcc_t quotPick;

   assign divOne = partialRem_t'(divisorNorm) << 1;
   assign divTwo = partialRem_t'(divisorNorm) << 2;

   // first step takes the aligned dividend as loaded
   assign sumIn = firstStep ? sumReg : (sumReg << 2);
   assign carryIn = firstStep ? carryReg : (carryReg << 2);

   assign estimate = sumIn[`REM_WIDTH-1 -: (`QST_SUM_BITS+1)]
                   + carryIn[`REM_WIDTH-1 -: (`QST_SUM_BITS+1)];
   assign remEstimate = estimate[`QST_SUM_BITS:1];
   assign divisorTop = divisorNorm[`DIV_WIDTH-2 -: `QST_DIV_BITS];

   assign posDigit = digit[3] | digit[2];
   assign negDigit = digit[1] | digit[0];

   // positive digits subtract via ones' complement
   always_comb
   begin
      case (digit)
         4'b1000:
         begin
            divMultiple = ~divTwo;
            {qIn, qmIn} = {2'd2, 2'd1};
         end
         4'b0100:
         begin
            divMultiple = ~divOne;
            {qIn, qmIn} = {2'd1, 2'd0};
         end
         4'b0010:
         begin
            divMultiple = divOne;
            {qIn, qmIn} = {2'd3, 2'd2};
         end
         4'b0001:
         begin
            divMultiple = divTwo;
            {qIn, qmIn} = {2'd2, 2'd1};
         end
         default:
         begin
            divMultiple = '0;
            {qIn, qmIn} = {2'd0, 2'd3};
         end
      endcase
   end

   assign carryUlp = {carryIn[`REM_WIDTH-1:1], posDigit};   // +1 rides in the free lsb
   assign csaSum = divMultiple ^ sumIn ^ carryUlp;
   assign csaCarry = ((divMultiple & sumIn) | (divMultiple & carryUlp)
                     | (sumIn & carryUlp)) << 1;

   assign quotQBase = negDigit ? quotQm : quotQ;
   assign quotQmBase = posDigit ? quotQ : quotQm;

   // negative final residual means one subtraction too many
   assign remRaw = sumReg + carryReg;
   assign remFixed = remRaw[`REM_WIDTH-1] ? (remRaw + divOne) : remRaw;
   assign quotPick = remRaw[`REM_WIDTH-1] ? quotQm : quotQ;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         firstStep <= 1'b0;
      else if (load)
         firstStep <= 1'b1;
      else if (iterate)
         firstStep <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         sumReg <= oddShift ? partialRem_t'(dividend) : (partialRem_t'(dividend) << 1);
         carryReg <= '0;
         quotQ <= '0;
         quotQm <= '1;
      end
      else if (iterate)
      begin
         sumReg <= csaSum;
         carryReg <= csaCarry;
         quotQ <= {quotQBase[`DIV_WIDTH-2:0], qIn};
         quotQm <= {quotQmBase[`DIV_WIDTH-2:0], qmIn};
      end

      if (finish)
      begin
         quotient <= quotPick[`DIV_WIDTH-1:0];
         remainder <= remFixed[`DIV_WIDTH:1] >> shiftAmt;   // undo the normalization
      end
   end

endmodule

// File: intDivider.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module intDivider import divPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        req,
   input  divRequest_t request,
   output logic        ack,
   output divResult_t  result
);

   logic capture;
   logic load;
   logic iterate;
   logic finish;
   word_t dividend;
   word_t divisorNorm;
   shiftAmt_t shiftAmt;
   logic oddShift;
   iterCount_t numIter;
   logic [`QST_SUM_BITS-1:0] remEstimate;
   logic [`QST_DIV_BITS-1:0] divisorTop;
   digit_t digit;

   divControl u_control (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .numIter (numIter),
      .divZero (result.divZero),
      .capture (capture),
      .load    (load),
      .iterate (iterate),
      .finish  (finish),
      .ack     (ack)
   );

   // operands held here for the whole divide
   divNormalize u_normalize (
      .clk         (clk),
      .reset       (reset),
      .capture     (capture),
      .request     (request),
      .dividend    (dividend),
      .divisorNorm (divisorNorm),
      .shiftAmt    (shiftAmt),
      .oddShift    (oddShift),
      .numIter     (numIter),
      .divZero     (result.divZero)
   );

   srtIteration u_iteration (
      .clk         (clk),
      .reset       (reset),
      .load        (load),
      .iterate     (iterate),
      .finish      (finish),
      .dividend    (dividend),
      .divisorNorm (divisorNorm),
      .shiftAmt    (shiftAmt),
      .oddShift    (oddShift),
      .digit       (digit),
      .remEstimate (remEstimate),
      .divisorTop  (divisorTop),
      .quotient    (result.quotient),
      .remainder   (result.remainder)
   );

   quotientSelect u_select (
      .remEstimate (remEstimate),
      .divisorTop  (divisorTop),
      .digit       (digit)
   );

endmodule

// File: intDivider_chk.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module intDividerChk import divPkg::*;
(
   input logic       clk,
   input logic       reset,
   input logic       req,
   input logic       capture,
   input logic       ack,
   input divResult_t result
);

   int failCount = 0;        // polled from the testbench
   int latency;              // edges since the capture edge
   logic pending;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pending <= 1'b0;
         latency <= 0;
      end
      else if (capture)
      begin
         pending <= 1'b1;
         latency <= 1;
      end
      else if (pending && ack)
         pending <= 1'b0;
      else if (pending)
         latency <= latency + 1;
   end

   // latency is still zero until the first capture after reset
   ackLowAfterReset: assert property (@(posedge clk) disable iff (reset) latency == 0 |-> !ack)
   else
   begin
      failCount = failCount + 1;
      $error("ack high after reset before any request was captured");
   end

   ackNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
   else
   begin
      failCount = failCount + 1;
      $error("ack rose without req");
   end

   // result frozen for as long as ack is held
   resultStable: assert property (@(posedge clk) disable iff (reset)
      ack && $past(ack) |-> $stable(result))
   else
   begin
      failCount = failCount + 1;
      $error("result changed while ack was high");
   end

   ackDrops: assert property (@(posedge clk) disable iff (reset) ack && !req |=> !ack)
   else
   begin
      failCount = failCount + 1;
      $error("ack stayed high after req fell");
   end

   ackLatency: assert property (@(posedge clk) disable iff (reset)
      pending && !ack |-> latency <= `MAX_ITER + 3)
   else
   begin
      failCount = failCount + 1;
      $error("ack later than the latency bound");
   end

endmodule

// File: intDividerTb.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module intDividerTb import divPkg::*;
();

   localparam int numRandom = 200;
   localparam int numDirected = 11;
   localparam int numTests = numRandom + numDirected;
   localparam int resetCycles = 10;
   localparam int clkPeriod = 4;
   localparam int ackLimit = `MAX_ITER + 8;

   logic clk;
   logic reset;
   logic req;
   divRequest_t request;
   logic ack;
   divResult_t result;

   integer seed = 67;
   word_t dirDividend [numDirected];
   word_t dirDivisor [numDirected];

   intDivider u_dut (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .request (request),
      .ack     (ack),
      .result  (result)
   );

   bind intDivider intDividerChk u_chk (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .capture (capture),
      .ack     (ack),
      .result  (result)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "run stopped");
   endtask

   task automatic compareValue(input string name, input word_t got, input word_t expected);
      assert (got === expected)
      else
      begin
         $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, expected);
         $display("Regression failed");
         $fatal(1, "result mismatch");
      end
   endtask

   // one full four-phase transfer, called right after a rising edge
   task automatic runDivide(input word_t a, input word_t b);
      int waited;
      int holdCycles;
      logic expZero;
      waited = 0;
      holdCycles = $unsigned($random(seed)) % 6;
      expZero = (b == '0);
      request.dividend <= a;
      request.divisor <= b;
      req <= 1'b1;
      @(posedge clk);
      while (!ack)
      begin
         if (waited > ackLimit)
            stopOnError("timeout: no ack for the current request");
         waited = waited + 1;
         @(posedge clk);
      end
      compareValue("result.divZero", word_t'(result.divZero), word_t'(expZero));
      if (!expZero)
      begin
         compareValue("result.quotient", result.quotient, a / b);
         compareValue("result.remainder", result.remainder, a % b);
      end
      repeat (holdCycles) @(posedge clk);   // back-pressure
      req <= 1'b0;
      @(posedge clk);
      while (ack)
         @(posedge clk);
   endtask

   initial
   begin
      word_t a;
      word_t b;
      int shiftBy;
      reset = 1'b1;
      req = 1'b0;
      request = '0;
      // divisor one, top bit set, small dividend, all ones, zero divisor
      dirDividend = '{32'd1000, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'd3, 32'd0,
                      32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd12345, 32'd0, 32'h8000_0000};
      dirDivisor = '{32'd1, 32'd1, 32'h8000_0000, 32'h8000_0001, 32'd7, 32'd9,
                     32'hFFFF_FFFF, 32'd3, 32'd0, 32'd0, 32'd2};
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      for (int i = 0; i < numDirected; i++)
         runDivide(dirDividend[i], dirDivisor[i]);
      for (int i = 0; i < numRandom; i++)
      begin
         a = $random(seed);
         shiftBy = $unsigned($random(seed)) % 32;
         b = word_t'($random(seed)) >> shiftBy;   // spreads the leading-zero count
         if (b == '0)
            b = 32'd1;
         runDivide(a, b);
      end
      $display("Regression passed");
      $finish;
   end

   // bound checker counts its own assertion failures
   initial
   begin
      wait (u_dut.u_chk.failCount != 0);
      stopOnError("an assertion in the bound checker fired");
   end

   initial
   begin
      #((numTests * ackLimit + resetCycles) * clkPeriod);
      stopOnError("watchdog expired before all tests finished");
   end

endmodule

// File: files.f
+incdir+.
divPkg.sv
quotientSelect.sv
divNormalize.sv
divControl.sv
srtIteration.sv
intDivider.sv
intDivider_chk.sv
intDividerTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= intDividerTb
FILELIST ?= files.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIMARGS ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Regression passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
